// ==== clockOverlay.f ====
+incdir+logic
logic/overlayPkg.sv
logic/digitBankLoader.sv
logic/glyphWindow.sv
logic/romAddressMerge.sv
logic/clockOverlay.sv
bench/clockOverlayTb.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the overlay testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

rm -rf "$BUILD_DIR"
rm -f "$LOG_FILE"

verilator --binary --timing -j 0 \
	--top-module clockOverlayTb \
	--Mdir "$BUILD_DIR" \
	-f clockOverlay.f

status=0
"./$BUILD_DIR/VclockOverlayTb" > "$LOG_FILE" 2>&1 || status=$?
cat "$LOG_FILE"

if grep -q "^>>> PASS$" "$LOG_FILE"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, exit status $status"
exit 1

// ==== bench/clockOverlayTb.sv ====
`timescale 1ns/100ps

`include "clockOverlay_settings.svh"

module clockOverlayTb
	import overlayPkg::*;
();

	typedef struct {
		string name;
		int image;
		pixelCoord x;
		pixelCoord y;
		bit frame;
	} stimRow;

	localparam int ROW_COUNT = 49;
	localparam int RANDOM_COUNT = 400;
	localparam int CYCLE_LIMIT = ROW_COUNT * 20 + RANDOM_COUNT + 100;

	// Parking spot outside every field
	localparam pixelCoord idleX = 10'd620;
	localparam pixelCoord idleY = 10'd470;

	logic CLK = 1'b0;
	logic RESET;
	pixelCoord PosX;
	pixelCoord PosY;
	memData MemData = '0;
	memAddr MemAddr;
	romAddr RomAddr;
	romSelect RomCs;

	memData memImage [16] = '{default: '0};
	memData shownImage [16] = '{default: '0};
	memData nextWord = '0;
	windowHit expectQ [$];
	string nameQ [$];
	windowHit expectedOut;
	string expectedName;
	logic [31:0] rngState = 32'd69081;
	int cycleCount = 0;

	// Items 1 to 12, year saturates in the first, day drops bit 7 in the second
	memData baseImage [1:12] = '{8'd37, 8'd52, 8'd13, 8'd28, 8'd11, 8'd120,
		8'd9, 8'd45, 8'd3, 8'h01, 8'h00, 8'h00};
	memData reloadImage [1:12] = '{8'd4, 8'd7, 8'd21, 8'd200, 8'd6, 8'd99,
		8'd58, 8'd0, 8'd17, 8'hFF, 8'h01, 8'd5};

	stimRow stimTable [ROW_COUNT] = '{
		'{"resetBackground", 0, 10'd5, 10'd5, 1'b0},
		'{"resetDayZero", 0, 10'd150, 10'd150, 1'b0},
		'{"resetActiveOff", 0, 10'd400, 10'd375, 1'b0},
		'{"dayTensTopLeft", 1, 10'd132, 10'd130, 1'b1},
		'{"dayTensBottomRight", 1, 10'd172, 10'd190, 1'b0},
		'{"dateGapBackground", 1, 10'd173, 10'd150, 1'b0},
		'{"dayOnes", 1, 10'd180, 10'd170, 1'b0},
		'{"monthTens", 1, 10'd250, 10'd135, 1'b0},
		'{"monthOnes", 1, 10'd290, 10'd160, 1'b0},
		'{"yearTensSaturated", 1, 10'd416, 10'd140, 1'b0},
		'{"yearOnesSaturated", 1, 10'd498, 10'd189, 1'b0},
		'{"clockHourTens", 1, 10'd38, 10'd300, 1'b0},
		'{"clockHourOnes", 1, 10'd120, 10'd348, 1'b0},
		'{"clockMinTens", 1, 10'd128, 10'd290, 1'b0},
		'{"clockMinOnes", 1, 10'd200, 10'd320, 1'b0},
		'{"clockSecTens", 1, 10'd218, 10'd288, 1'b0},
		'{"clockSecOnes", 1, 10'd300, 10'd340, 1'b0},
		'{"watchHourTens", 1, 10'd340, 10'd300, 1'b0},
		'{"watchHourOnes", 1, 10'd400, 10'd310, 1'b0},
		'{"watchMinTens", 1, 10'd450, 10'd300, 1'b0},
		'{"watchMinOnes", 1, 10'd511, 10'd348, 1'b0},
		'{"watchSecTens", 1, 10'd519, 10'd288, 1'b0},
		'{"watchSecOnes", 1, 10'd601, 10'd300, 1'b0},
		'{"ringOn", 1, 10'd520, 10'd380, 1'b0},
		'{"activeOff", 1, 10'd338, 10'd370, 1'b0},
		'{"cursor1SecBlank", 2, 10'd230, 10'd343, 1'b1},
		'{"cursor1SecAbove", 2, 10'd230, 10'd342, 1'b0},
		'{"cursor1MinKeeps", 2, 10'd140, 10'd345, 1'b0},
		'{"cursor2MinBlank", 3, 10'd180, 10'd348, 1'b1},
		'{"cursor3HourBlank", 4, 10'd50, 10'd345, 1'b1},
		'{"cursor4DayBlank", 5, 10'd140, 10'd185, 1'b1},
		'{"cursor4MonthKeeps", 5, 10'd240, 10'd187, 1'b0},
		'{"cursor5MonthBlank", 6, 10'd280, 10'd190, 1'b1},
		'{"cursor6YearBlank", 7, 10'd420, 10'd186, 1'b1},
		'{"cursor6YearAbove", 7, 10'd420, 10'd184, 1'b0},
		'{"cursor7WatchSecBlank", 8, 10'd530, 10'd344, 1'b1},
		'{"cursor8WatchMinBlank", 9, 10'd440, 10'd346, 1'b1},
		'{"cursor9WatchHourBlank", 10, 10'd390, 10'd347, 1'b1},
		'{"cursor9SecKeeps", 10, 10'd530, 10'd347, 1'b0},
		'{"ringOff", 10, 10'd550, 10'd388, 1'b0},
		'{"activeOn", 10, 10'd438, 10'd380, 1'b0},
		'{"reloadDayTens", 11, 10'd150, 10'd150, 1'b1},
		'{"reloadHourOnes", 11, 10'd100, 10'd300, 1'b0},
		'{"reloadWatchSecOnes", 11, 10'd580, 10'd320, 1'b0},
		'{"reloadYearOnes", 11, 10'd460, 10'd150, 1'b0},
		'{"reloadRingOn", 11, 10'd600, 10'd388, 1'b0},
		'{"outsideTop", 11, 10'd300, 10'd10, 1'b0},
		'{"outsideCorner", 11, 10'd639, 10'd479, 1'b0},
		'{"outsideTimeGap", 11, 10'd125, 10'd300, 1'b0}
	};

	clockOverlay i_clockOverlay (
		.CLK(CLK),
		.RESET(RESET),
		.PosX(PosX),
		.PosY(PosY),
		.MemData(MemData),
		.MemAddr(MemAddr),
		.RomAddr(RomAddr),
		.RomCs(RomCs)
	);

	always #10 CLK = ~CLK;

	// Register memory, one cycle read latency
	always @(negedge CLK)
		nextWord = memImage[MemAddr];

	always @(posedge CLK)
	begin
		#2;
		MemData = nextWord;
	end

	////////////////////
	// Reporting
	////////////////////

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic checkSelect(input string name, input romSelect expected, input romSelect actual);
		if (actual !== expected)
			abortRun($sformatf("error %s: expected RomCs %b, actual %b", name, expected, actual));
	endtask

	task automatic checkAddr(input string name, input romAddr expected, input romAddr actual);
		if (actual !== expected)
			abortRun($sformatf("error %s: expected RomAddr %0d, actual %0d", name, expected, actual));
	endtask

	task automatic checkMemAddr(input string name, input memAddr expected, input memAddr actual);
		if (actual !== expected)
			abortRun($sformatf("error %s: expected MemAddr %0d, actual %0d", name, expected, actual));
	endtask

	always @(posedge CLK)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > CYCLE_LIMIT)
			abortRun($sformatf("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	// Output for a position shows up two pushes later
	always @(negedge CLK)
	begin
		if (expectQ.size() == 3)
		begin
			expectedOut = expectQ.pop_front();
			expectedName = nameQ.pop_front();
			checkSelect(expectedName, expectedOut.select, RomCs);
			checkAddr(expectedName, expectedOut.addr, RomAddr);
		end
	end

	////////////////////
	// Reference model
	////////////////////

	function automatic windowHit modelOutput(input pixelCoord x, input pixelCoord y);
		windowHit result;
		layoutEntry e;
		bit isDigit;
		bit blanked;
		int dx;
		int dy;
		int w;
		int h;
		int value;
		int glyph;
		result.hit = 1'b0;
		result.select = 2'b00;
		result.addr = romAddr'(int'(x) + `SCREEN_WIDTH * int'(y));
		for (int s = 0; s < `WINDOW_COUNT; s++)
		begin
			e = overlayLayout[s];
			isDigit = (e.kind == digitTens) || (e.kind == digitOnes);
			dx = int'(x) - int'(e.left);
			dy = int'(y) - int'(e.top);
			if (isDigit)
			begin
				w = `DIGIT_WIDTH;
				h = `DIGIT_HEIGHT;
				value = int'(shownImage[int'(e.item) + 1][6:0]);
				if (value > 99)
					value = 99;
				glyph = (e.kind == digitTens) ? value / 10 : value % 10;
				blanked = (shownImage[12] == memData'(e.cursorCode))
					&& (dy >= h - `UNDERLINE_ROWS);
			end
			else
			begin
				w = `INDICATOR_WIDTH;
				h = `INDICATOR_HEIGHT;
				glyph = (e.kind == indicatorRing) ? int'(shownImage[10][0])
					: int'(shownImage[11][0]);
				blanked = 1'b0;
			end
			// First field in table order wins
			if (!result.hit && !blanked && dx >= 0 && dx <= w && dy >= 0 && dy <= h)
			begin
				result.hit = 1'b1;
				if (isDigit)
				begin
					result.select = 2'b01;
					result.addr = romAddr'(dx + `DIGIT_WIDTH * (dy + `DIGIT_HEIGHT * glyph));
				end
				else
				begin
					result.select = 2'b11;
					result.addr = romAddr'(dx + `INDICATOR_WIDTH
						* (dy + `INDICATOR_STRIDE * glyph));
				end
			end
		end
		return result;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	////////////////////
	// Stimulus
	////////////////////

	task automatic loadImage(input int id);
		for (int a = 0; a < 16; a++)
		begin
			memImage[a] = {4'hA, 4'(a)};
			if (a >= 1 && a <= `BANK_ITEMS)
			begin
				case (id)
					0: memImage[a] = '0;
					11: memImage[a] = reloadImage[a];
					default: memImage[a] = baseImage[a];
				endcase
			end
		end
		// Cursor images, ring off and active on
		if (id >= 2 && id <= 10)
		begin
			memImage[10] = 8'h02;
			memImage[11] = 8'h03;
			memImage[12] = memData'(id - 1);
		end
	endtask

	task automatic driveCycle(input string name, input pixelCoord x, input pixelCoord y);
		@(posedge CLK);
		#2;
		PosX = x;
		PosY = y;
		expectQ.push_back(modelOutput(x, y));
		nameQ.push_back(name);
	endtask

	task automatic runFrameStart(input string name);
		driveCycle(name, '0, '0);
		for (int k = 1; k <= 14; k++)
		begin
			driveCycle(name, idleX, idleY);
			@(negedge CLK);
			if (k <= `BANK_ITEMS)
				checkMemAddr(name, memAddr'(k), MemAddr);
			else
				checkMemAddr(name, '0, MemAddr);
		end
		shownImage = memImage;
	endtask

	task automatic applyRow(input stimRow row);
		if (row.frame)
		begin
			loadImage(row.image);
			runFrameStart(row.name);
		end
		driveCycle(row.name, row.x, row.y);
	endtask

	// Half near a field edge, half anywhere on screen
	task automatic runRandomProbes();
		layoutEntry pick;
		int slot;
		int x;
		int y;
		int w;
		int h;
		for (int n = 0; n < RANDOM_COUNT; n++)
		begin
			rngState = xorshift(rngState);
			if (rngState[31])
			begin
				slot = int'(rngState[4:0]) % `WINDOW_COUNT;
				pick = overlayLayout[slot];
				w = (pick.kind == digitTens || pick.kind == digitOnes) ? `DIGIT_WIDTH
					: `INDICATOR_WIDTH;
				h = (pick.kind == digitTens || pick.kind == digitOnes) ? `DIGIT_HEIGHT
					: `INDICATOR_HEIGHT;
				x = int'(pick.left) - 1 + int'(rngState[15:8]) % (w + 3);
				y = int'(pick.top) - 1 + int'(rngState[29:22]) % (h + 3);
			end
			else
			begin
				x = int'(rngState[25:16]) % `SCREEN_WIDTH;
				y = int'(rngState[8:0]) % 480;
			end
			// Origin would start a new frame
			if (x == 0 && y == 0)
				x = 1;
			driveCycle($sformatf("random%0d", n), pixelCoord'(x), pixelCoord'(y));
		end
	endtask

	initial
	begin
		RESET = 1'b1;
		PosX = idleX;
		PosY = idleY;
		repeat (8) @(posedge CLK);
		#2;
		RESET = 1'b0;
		@(negedge CLK);
		checkSelect("reset", selBackground, RomCs);
		checkAddr("reset", '0, RomAddr);
		checkMemAddr("reset", '0, MemAddr);
		for (int i = 0; i < ROW_COUNT; i++)
			applyRow(stimTable[i]);
		runRandomProbes();
		// Push the last probe out of the pipeline
		driveCycle("flush", idleX, idleY);
		driveCycle("flush", idleX, idleY);
		@(posedge CLK);
		$display(">>> PASS");
		$finish;
	end

endmodule

// ==== logic/clockOverlay.sv ====
`timescale 1ns/100ps

`include "clockOverlay_settings.svh"

module clockOverlay
	import overlayPkg::*;
(
	input logic CLK,
	input logic RESET,
	input pixelCoord PosX,
	input pixelCoord PosY,
	input memData MemData,
	output memAddr MemAddr,
	output romAddr RomAddr,
	output romSelect RomCs
);

	displayBank bank;
	windowHit hits [`WINDOW_COUNT];

	// Refreshes the bank in a burst after every frame start
	digitBankLoader i_digitBankLoader (
		.CLK(CLK),
		.RESET(RESET),
		.PosX(PosX),
		.PosY(PosY),
		.MemData(MemData),
		.MemAddr(MemAddr),
		.Bank(bank)
	);

	////////////////////
	// Screen fields
	////////////////////

	for (genvar slot = 0; slot < `WINDOW_COUNT; slot++)
	begin : windowSlot
		glyphWindow #(
			.SLOT(slot)
		) i_glyphWindow (
			.CLK(CLK),
			.RESET(RESET),
			.PosX(PosX),
			.PosY(PosY),
			.Bank(bank),
			.Hit(hits[slot])
		);
	end

	// Result of a position appears two cycles later
	romAddressMerge i_romAddressMerge (
		.CLK(CLK),
		.RESET(RESET),
		.PosX(PosX),
		.PosY(PosY),
		.Hits(hits),
		.RomAddr(RomAddr),
		.RomCs(RomCs)
	);

endmodule

// ==== logic/romAddressMerge.sv ====
`timescale 1ns/100ps

`include "clockOverlay_settings.svh"

module romAddressMerge
	import overlayPkg::*;
(
	input logic CLK,
	input logic RESET,
	input pixelCoord PosX,
	input pixelCoord PosY,
	input windowHit Hits [`WINDOW_COUNT],
	output romAddr RomAddr,
	output romSelect RomCs
);

	pixelCoord delayX;
	pixelCoord delayY;
	romAddr backgroundAddr;
	romSelect chosenSel;
	romAddr chosenAddr;

	// Line up the position with the registered window results
	always_ff @(posedge CLK)
	begin
		delayX <= PosX;
		delayY <= PosY;
	end

	assign backgroundAddr = romAddr'(delayX) + romAddr'(`SCREEN_WIDTH) * romAddr'(delayY);

	////////////////////
	// Priority pick
	////////////////////

	// Walk from the top so the lowest slot is applied last
	always_comb
	begin
		chosenSel = selBackground;
		chosenAddr = backgroundAddr;
		for (int i = `WINDOW_COUNT - 1; i >= 0; i--)
		begin
			if (Hits[i].hit)
			begin
				chosenSel = Hits[i].select;
				chosenAddr = Hits[i].addr;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			RomCs <= selBackground;
			RomAddr <= '0;
		end
		else
		begin
			RomCs <= chosenSel;
			RomAddr <= chosenAddr;
		end
	end

endmodule

// ==== logic/glyphWindow.sv ====
`timescale 1ns/100ps

`include "clockOverlay_settings.svh"

module glyphWindow
	import overlayPkg::*;
#(
	parameter int SLOT = 0
)
(
	input logic CLK,
	input logic RESET,
	input pixelCoord PosX,
	input pixelCoord PosY,
	input displayBank Bank,
	output windowHit Hit
);

	localparam layoutEntry entry = overlayLayout[SLOT];
	localparam bit isDigit = (entry.kind == digitTens) || (entry.kind == digitOnes);

	// Field geometry, edges inclusive
	localparam int fieldWidth = isDigit ? `DIGIT_WIDTH : `INDICATOR_WIDTH;
	localparam int fieldHeight = isDigit ? `DIGIT_HEIGHT : `INDICATOR_HEIGHT;
	localparam int rowStride = isDigit ? `DIGIT_HEIGHT : `INDICATOR_STRIDE;
	localparam romSelect glyphSelect = isDigit ? selDigit : selIndicator;
	localparam pixelCoord rightX = pixelCoord'(entry.left + fieldWidth);
	localparam pixelCoord bottomY = pixelCoord'(entry.top + fieldHeight);
	localparam pixelCoord underlineY = pixelCoord'(entry.top + fieldHeight - `UNDERLINE_ROWS);

	digitPair shownPair;
	bcdDigit glyphIndex;
	logic inRect;
	logic underCursor;
	pixelCoord relX;
	pixelCoord relY;
	romAddr glyphRow;
	romAddr glyphAddr;

	// Item is constant per slot, so this folds to plain wiring
	always_comb
	begin
		case (entry.item)
			4'd0: shownPair = Bank.clockSec;
			4'd1: shownPair = Bank.clockMin;
			4'd2: shownPair = Bank.clockHour;
			4'd3: shownPair = Bank.day;
			4'd4: shownPair = Bank.month;
			4'd5: shownPair = Bank.year;
			4'd6: shownPair = Bank.watchSec;
			4'd7: shownPair = Bank.watchMin;
			default: shownPair = Bank.watchHour;
		endcase
	end

	// Digit value, or the on/off image of an indicator
	always_comb
	begin
		case (entry.kind)
			digitTens: glyphIndex = shownPair.tens;
			digitOnes: glyphIndex = shownPair.ones;
			indicatorRing: glyphIndex = bcdDigit'(Bank.ringFlag);
			default: glyphIndex = bcdDigit'(Bank.activeFlag);
		endcase
	end

	assign inRect = (PosX >= entry.left) && (PosX <= rightX)
		&& (PosY >= entry.top) && (PosY <= bottomY);

	// Blank the bottom rows of the field being edited
	assign underCursor = isDigit && (Bank.cursor == memData'(entry.cursorCode))
		&& (PosY >= underlineY);

	assign relX = PosX - entry.left;
	assign relY = PosY - entry.top;
	assign glyphRow = romAddr'(relY) + romAddr'(glyphIndex) * romAddr'(rowStride);
	assign glyphAddr = romAddr'(relX) + romAddr'(fieldWidth) * glyphRow;

	always_ff @(posedge CLK)
	begin
		Hit.select <= glyphSelect;
		Hit.addr <= glyphAddr;
		if (RESET)
			Hit.hit <= 1'b0;
		else
			Hit.hit <= inRect && !underCursor;
	end

endmodule

// ==== logic/digitBankLoader.sv ====
`timescale 1ns/100ps

`include "clockOverlay_settings.svh"

module digitBankLoader
	import overlayPkg::*;
(
	input logic CLK,
	input logic RESET,
	input pixelCoord PosX,
	input pixelCoord PosY,
	input memData MemData,
	output memAddr MemAddr,
	output displayBank Bank
);

	loaderState state;
	memAddr prevAddr;
	logic frameStart;
	logic [6:0] rawValue;
	logic [6:0] satValue;
	bcdDigit tensValue;
	digitPair convPair;

	assign frameStart = (PosX == '0) && (PosY == '0);

	////////////////////
	// Saturate and split
	////////////////////

	// Only two digits fit on screen
	assign rawValue = MemData[6:0];
	assign satValue = (rawValue > 7'd99) ? 7'd99 : rawValue;

	// Tens by threshold compare, ones by subtraction
	always_comb
	begin
		tensValue = '0;
		for (int t = 1; t <= 9; t++)
		begin
			if (satValue >= 7'(t * 10))
				tensValue = bcdDigit'(t);
		end
		convPair.tens = tensValue;
		convPair.ones = bcdDigit'(satValue - 7'(tensValue) * 7'd10);
	end

	////////////////////
	// Burst sequencer
	////////////////////

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			state <= idle;
			MemAddr <= '0;
			prevAddr <= '0;
		end
		else
		begin
			// Tags the word coming back next cycle
			prevAddr <= MemAddr;
			case (state)
				idle:
				begin
					if (frameStart)
					begin
						MemAddr <= memAddr'(1);
						state <= fetch;
					end
				end
				fetch:
				begin
					if (MemAddr == memAddr'(`BANK_ITEMS))
					begin
						MemAddr <= '0;
						state <= last;
					end
					else
						MemAddr <= MemAddr + 1'b1;
				end
				// Final word lands here
				default:
					state <= idle;
			endcase
		end
	end

	////////////////////
	// Display bank
	////////////////////

	// Address zero is never an item, so it doubles as no-write
	always_ff @(posedge CLK)
	begin
		if (RESET)
			Bank <= '0;
		else
		begin
			case (prevAddr)
				4'd1: Bank.clockSec <= convPair;
				4'd2: Bank.clockMin <= convPair;
				4'd3: Bank.clockHour <= convPair;
				4'd4: Bank.day <= convPair;
				4'd5: Bank.month <= convPair;
				4'd6: Bank.year <= convPair;
				4'd7: Bank.watchSec <= convPair;
				4'd8: Bank.watchMin <= convPair;
				4'd9: Bank.watchHour <= convPair;
				4'd10: Bank.ringFlag <= MemData[0];
				4'd11: Bank.activeFlag <= MemData[0];
				4'd12: Bank.cursor <= MemData;
				default: ;
			endcase
		end
	end

endmodule

// ==== logic/overlayPkg.sv ====
`include "clockOverlay_settings.svh"

package overlayPkg;

	////////////////////
	// Plain vectors
	////////////////////

	typedef logic [9:0] pixelCoord;
	typedef logic [18:0] romAddr;
	typedef logic [1:0] romSelect;
	typedef logic [3:0] bcdDigit;
	typedef logic [3:0] memAddr;
	typedef logic [7:0] memData;

	// Chip select codes
	localparam romSelect selBackground = 2'b00;
	localparam romSelect selDigit = 2'b01;
	localparam romSelect selIndicator = 2'b11;

	////////////////////
	// Structs and enums
	////////////////////

	typedef struct packed {
		bcdDigit tens;
		bcdDigit ones;
	} digitPair;

	// Digit pairs in register memory order
	typedef struct packed {
		digitPair clockSec;
		digitPair clockMin;
		digitPair clockHour;
		digitPair day;
		digitPair month;
		digitPair year;
		digitPair watchSec;
		digitPair watchMin;
		digitPair watchHour;
		logic ringFlag;
		logic activeFlag;
		memData cursor;
	} displayBank;

	typedef enum logic [1:0] {
		digitTens,
		digitOnes,
		indicatorRing,
		indicatorActive
	} windowKind;

	typedef struct packed {
		logic hit;
		romSelect select;
		romAddr addr;
	} windowHit;

	// Item is the bank digit pair, unused for indicators
	typedef struct packed {
		pixelCoord left;
		pixelCoord top;
		windowKind kind;
		logic [3:0] item;
		logic [3:0] cursorCode;
	} layoutEntry;

	typedef enum logic [1:0] {
		idle,
		fetch,
		last
	} loaderState;

	////////////////////
	// Screen layout
	////////////////////

	localparam pixelCoord dateRowY = 10'd130;
	localparam pixelCoord timeRowY = 10'd288;
	localparam pixelCoord indicatorRowY = 10'd370;

	// Lower slot wins where fields overlap
	localparam layoutEntry overlayLayout [`WINDOW_COUNT] = '{
		'{10'd132, dateRowY, digitTens, 4'd3, 4'd4},
		'{10'd174, dateRowY, digitOnes, 4'd3, 4'd4},
		'{10'd232, dateRowY, digitTens, 4'd4, 4'd5},
		'{10'd274, dateRowY, digitOnes, 4'd4, 4'd5},
		'{10'd416, dateRowY, digitTens, 4'd5, 4'd6},
		'{10'd458, dateRowY, digitOnes, 4'd5, 4'd6},
		'{10'd38, timeRowY, digitTens, 4'd2, 4'd3},
		'{10'd80, timeRowY, digitOnes, 4'd2, 4'd3},
		'{10'd128, timeRowY, digitTens, 4'd1, 4'd2},
		'{10'd170, timeRowY, digitOnes, 4'd1, 4'd2},
		'{10'd218, timeRowY, digitTens, 4'd0, 4'd1},
		'{10'd260, timeRowY, digitOnes, 4'd0, 4'd1},
		'{10'd339, timeRowY, digitTens, 4'd8, 4'd9},
		'{10'd381, timeRowY, digitOnes, 4'd8, 4'd9},
		'{10'd429, timeRowY, digitTens, 4'd7, 4'd8},
		'{10'd471, timeRowY, digitOnes, 4'd7, 4'd8},
		'{10'd519, timeRowY, digitTens, 4'd6, 4'd7},
		'{10'd561, timeRowY, digitOnes, 4'd6, 4'd7},
		'{10'd338, indicatorRowY, indicatorActive, 4'd0, 4'd0},
		'{10'd500, indicatorRowY, indicatorRing, 4'd0, 4'd0}
	};

endpackage

// ==== logic/clockOverlay_settings.svh ====
`ifndef CLOCK_OVERLAY_SETTINGS_SVH
`define CLOCK_OVERLAY_SETTINGS_SVH

////////////////////
// Screen geometry
////////////////////

// Row stride of the background image
`define SCREEN_WIDTH 640

////////////////////
// Glyph sizes
////////////////////

// Digit field, also the row stride inside the digit strip
`define DIGIT_WIDTH 40
`define DIGIT_HEIGHT 60

// Status indicator field
`define INDICATOR_WIDTH 100
`define INDICATOR_HEIGHT 18

// Rows between the off and on image of an indicator
`define INDICATOR_STRIDE 20

// Cursor underline depth at the bottom of a digit
`define UNDERLINE_ROWS 5

// Number of screen fields and register memory items
`define WINDOW_COUNT 20
`define BANK_ITEMS 12

`endif
